// File: all.f
source/sifh_pkg.sv
source/hist_bank_if.sv
source/hist_sequencer.sv
source/bin_ram.sv
source/hist_readout.sv
source/sifh_hist_top.sv
tb/sifh_hist_sva.sv
tb/hist_checker.sv
tb/tb_sifh_hist.sv

// File: source/bin_ram.sv
`timescale 1ns/10ps
`default_nettype none

module bin_ram
    import sifh_pkg::*;
#(
    parameter int BIN_NUM   = BIN_NUM_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int COUNT_W   = COUNT_W_DEF
)(
    input  logic      clk,
    input  logic      res,
    hist_bank_if.bank bank
);

    localparam int ADDR_W = $clog2(PIXEL_NUM) + $clog2(BIN_NUM);
    localparam int DEPTH  = PIXEL_NUM * BIN_NUM;

    localparam logic [COUNT_W-1:0] CNT_MAX = '1;

    logic [COUNT_W-1:0] mem [DEPTH];

    // stage two holds the value read in stage one
    logic               st2_valid;
    logic [ADDR_W-1:0]  st2_addr;
    logic [COUNT_W-1:0] st2_cnt;
    logic [COUNT_W-1:0] st2_next;
    logic               fwd;

    function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] v);
        return (v == CNT_MAX) ? v : v + 1'b1;
    endfunction

    assign st2_next = sat_inc(st2_cnt);

    // same bin twice in a row, memory not yet written
    assign fwd = st2_valid && (st2_addr == bank.inc_addr);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            st2_valid <= 1'b0;
        end else begin
            st2_valid <= bank.inc_en;
        end
    end

    // stage one read
    always_ff @(posedge clk) begin
        if (bank.inc_en) begin
            st2_addr <= bank.inc_addr;
            if (fwd) begin
                st2_cnt <= st2_next;
            end else begin
                st2_cnt <= mem[bank.inc_addr];
            end
        end
    end

    // single write port, clear and increment never overlap
    always_ff @(posedge clk) begin
        if (bank.clr_en) begin
            mem[bank.clr_addr] <= '0;
        end else if (st2_valid) begin
            mem[st2_addr] <= st2_next;
        end
    end

    always_ff @(posedge clk) begin
        if (bank.rd_en) begin
            bank.rd_data <= mem[bank.rd_addr];  // registered read
        end
    end

endmodule

`default_nettype wire

// File: source/hist_bank_if.sv
`timescale 1ns/10ps
`default_nettype none

interface hist_bank_if
    import sifh_pkg::*;
#(
    parameter int ADDR_W  = $clog2(BIN_NUM_DEF * PIXEL_NUM_DEF),
    parameter int COUNT_W = COUNT_W_DEF
);

    logic              inc_en;   // one strobe per accepted hit
    logic [ADDR_W-1:0] inc_addr;
    logic              clr_en;
    logic [ADDR_W-1:0] clr_addr;
    logic               rd_en;
    logic [ADDR_W-1:0]  rd_addr;
    logic [COUNT_W-1:0] rd_data;  // one cycle after rd_en

    modport seq  (output inc_en, inc_addr, clr_en, clr_addr);
    modport rd   (output rd_en, rd_addr, input rd_data);
    modport bank (input inc_en, inc_addr, clr_en, clr_addr, rd_en, rd_addr,
                  output rd_data);

endinterface

`default_nettype wire

// File: source/hist_readout.sv
`timescale 1ns/10ps
`default_nettype none

module hist_readout
    import sifh_pkg::*;
#(
    parameter int BIN_NUM   = BIN_NUM_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int COUNT_W   = COUNT_W_DEF
)(
    input  logic                         clk,
    input  logic                         res,
    input  logic                         start,
    output logic                         done,
    hist_bank_if.rd                      bank,
    output logic                         bin_valid,
    output logic [$clog2(PIXEL_NUM)-1:0] bin_pixel,
    output logic [$clog2(BIN_NUM)-1:0]   bin_index,
    output logic [COUNT_W-1:0]           bin_count
);

    localparam int BIN_W  = $clog2(BIN_NUM);
    localparam int PIX_W  = $clog2(PIXEL_NUM);
    localparam int ADDR_W = PIX_W + BIN_W;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(PIXEL_NUM * BIN_NUM - 1);

    logic              active;
    logic [ADDR_W-1:0] addr_cnt;  // pixel-major sweep
    logic              last;

    assign last = active && (addr_cnt == LAST_ADDR);

    assign bank.rd_en   = active;
    assign bank.rd_addr = addr_cnt;
    assign bin_count    = bank.rd_data;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active    <= 1'b0;
            addr_cnt  <= '0;
            bin_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (start) begin
                active   <= 1'b1;
                addr_cnt <= '0;
            end else if (active) begin
                addr_cnt <= addr_cnt + 1'b1;
                if (last) begin
                    active <= 1'b0;
                end
            end
            // one cycle behind, lines up with rd_data
            bin_valid <= active;
            done      <= last;
        end
    end

    always_ff @(posedge clk) begin
        {bin_pixel, bin_index} <= addr_cnt;
    end

endmodule

`default_nettype wire

// File: source/hist_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module hist_sequencer
    import sifh_pkg::*;
#(
    parameter int BIN_NUM   = BIN_NUM_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int DATA_NUM  = DATA_NUM_DEF,
    parameter int ACQ_NUM   = ACQ_NUM_DEF
)(
    input  logic                       clk,
    input  logic                       res,
    input  logic                       hit,
    input  logic [$clog2(BIN_NUM)-1:0] hit_bin,
    hist_bank_if.seq                   bank,
    output logic                       start,
    input  logic                       done,
    output logic                       busy,
    output logic                       hist_num
);

    localparam int BIN_W  = $clog2(BIN_NUM);
    localparam int PIX_W  = $clog2(PIXEL_NUM);
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam int DATA_W = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W  = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(PIXEL_NUM * BIN_NUM - 1);
    localparam logic [DATA_W-1:0] LAST_DATA = DATA_W'(DATA_NUM - 1);
    localparam logic [PIX_W-1:0]  LAST_PIX  = PIX_W'(PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0]  LAST_ACQ  = ACQ_W'(ACQ_NUM - 1);

    hist_state_t       state;
    logic [ADDR_W-1:0] clr_cnt;
    logic [DATA_W-1:0] data_cnt;  // hits in current pixel
    logic [PIX_W-1:0]  pix_cnt;
    logic [ACQ_W-1:0]  acq_cnt;
    logic              drain_cnt;
    logic              accept;

    assign busy   = (state != ACCUMULATE);
    assign accept = hit && !busy;

    // pixel picked by the hit's position in the count order
    assign bank.inc_en   = accept;
    assign bank.inc_addr = {pix_cnt, hit_bin};
    assign bank.clr_en   = (state == CLEAR);
    assign bank.clr_addr = clr_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= CLEAR;
            clr_cnt   <= '0;
            data_cnt  <= '0;
            pix_cnt   <= '0;
            acq_cnt   <= '0;
            drain_cnt <= 1'b0;
            start     <= 1'b0;
            hist_num  <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                CLEAR: begin
                    if (clr_cnt == LAST_ADDR) begin
                        clr_cnt <= '0;
                        state   <= ACCUMULATE;
                    end else begin
                        clr_cnt <= clr_cnt + 1'b1;
                    end
                end
                ACCUMULATE: begin
                    if (accept) begin
                        if (data_cnt == LAST_DATA) begin
                            data_cnt <= '0;
                            if (pix_cnt == LAST_PIX) begin
                                pix_cnt <= '0;
                                if (acq_cnt == LAST_ACQ) begin
                                    acq_cnt <= '0;
                                    state   <= DRAIN;  // histogram complete
                                end else begin
                                    acq_cnt <= acq_cnt + 1'b1;
                                end
                            end else begin
                                pix_cnt <= pix_cnt + 1'b1;
                            end
                        end else begin
                            data_cnt <= data_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // two cycles cover the increment pipeline
                    if (drain_cnt) begin
                        drain_cnt <= 1'b0;
                        start     <= 1'b1;
                        state     <= READOUT;
                    end else begin
                        drain_cnt <= 1'b1;
                    end
                end
                READOUT: begin
                    if (done) begin
                        hist_num <= ~hist_num;
                        state    <= CLEAR;
                    end
                end
                default: state <= CLEAR;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/sifh_hist_top.sv
`timescale 1ns/10ps
`default_nettype none

module sifh_hist_top
    import sifh_pkg::*;
#(
    parameter int BIN_NUM   = BIN_NUM_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int DATA_NUM  = DATA_NUM_DEF,
    parameter int ACQ_NUM   = ACQ_NUM_DEF,
    parameter int COUNT_W   = COUNT_W_DEF
)(
    input  logic                         clk,
    input  logic                         res,
    input  logic                         hit,
    input  logic [$clog2(BIN_NUM)-1:0]   hit_bin,
    output logic                         busy,
    output logic                         bin_valid,
    output logic [$clog2(PIXEL_NUM)-1:0] bin_pixel,
    output logic [$clog2(BIN_NUM)-1:0]   bin_index,
    output logic [COUNT_W-1:0]           bin_count,
    output logic                         hist_num,
    output logic                         hist_done
);

    // pixel and bin counts are powers of two
    localparam int ADDR_W = $clog2(PIXEL_NUM) + $clog2(BIN_NUM);

    logic start;

    hist_bank_if #(.ADDR_W(ADDR_W), .COUNT_W(COUNT_W)) u_bank_if ();

    hist_sequencer #(
        .BIN_NUM   (BIN_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) u_hist_sequencer (
        .clk      (clk),
        .res      (res),
        .hit      (hit),
        .hit_bin  (hit_bin),
        .bank     (u_bank_if.seq),
        .start    (start),
        .done     (hist_done),  // readout done doubles as hist_done
        .busy     (busy),
        .hist_num (hist_num)
    );

    bin_ram #(
        .BIN_NUM   (BIN_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .COUNT_W   (COUNT_W)
    ) u_bin_ram (
        .clk  (clk),
        .res  (res),
        .bank (u_bank_if.bank)
    );

    hist_readout #(
        .BIN_NUM   (BIN_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .COUNT_W   (COUNT_W)
    ) u_hist_readout (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .done      (hist_done),
        .bank      (u_bank_if.rd),
        .bin_valid (bin_valid),
        .bin_pixel (bin_pixel),
        .bin_index (bin_index),
        .bin_count (bin_count)
    );

endmodule

`default_nettype wire

// File: source/sifh_pkg.sv
`default_nettype none

package sifh_pkg;

    // histogram geometry
    localparam int BIN_NUM_DEF   = 16;  // bins per pixel
    localparam int PIXEL_NUM_DEF = 4;   // pixels per frame

    // counting structure of the sequencer
    localparam int DATA_NUM_DEF  = 8;   // hits per pixel
    localparam int ACQ_NUM_DEF   = 3;   // frames per histogram

    // counters stop at 2**COUNT_W - 1
    localparam int COUNT_W_DEF   = 6;

    typedef enum logic [1:0] {
        CLEAR      = 2'b00,  // zero sweep over the bin memory
        ACCUMULATE = 2'b01,  // hits accepted here only
        DRAIN      = 2'b10,
        READOUT    = 2'b11
    } hist_state_t;

endpackage

`default_nettype wire

// File: tb/hist_checker.sv
`timescale 1ns/10ps
`default_nettype none

module hist_checker
    import sifh_pkg::*;
#(
    parameter int BIN_NUM   = BIN_NUM_DEF,
    parameter int PIXEL_NUM = PIXEL_NUM_DEF,
    parameter int DATA_NUM  = DATA_NUM_DEF,
    parameter int ACQ_NUM   = ACQ_NUM_DEF,
    parameter int COUNT_W   = COUNT_W_DEF
)(
    input  logic                         clk,
    input  logic                         res,
    input  logic                         hit,
    input  logic [$clog2(BIN_NUM)-1:0]   hit_bin,
    input  logic                         busy,
    input  logic                         bin_valid,
    input  logic [$clog2(PIXEL_NUM)-1:0] bin_pixel,
    input  logic [$clog2(BIN_NUM)-1:0]   bin_index,
    input  logic [COUNT_W-1:0]           bin_count,
    input  logic                         hist_num,
    input  logic                         hist_done,
    output int                           err_count
);

    localparam int CELLS     = PIXEL_NUM * BIN_NUM;
    localparam int HIST_HITS = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int CNT_MAX   = (1 << COUNT_W) - 1;
    localparam int FIRST_GAP = 5;  // last hit to first bin over drain, start and read

    int model [CELLS];
    int hit_total;  // accepted hits of the running histogram
    int beat;
    int exp_num;
    int cyc;
    int last_hit_cyc;
    int clr_len;
    bit clr_watch;
    bit in_readout;

    // pixel from the hit's running order, bin from the hit itself
    function automatic int ref_addr(input int order, input int bin);
        int pixel;
        pixel = (order / DATA_NUM) % PIXEL_NUM;
        return pixel * BIN_NUM + bin;
    endfunction

    function automatic int sat_add(input int count);
        return (count >= CNT_MAX) ? CNT_MAX : count + 1;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic new_histogram();
        foreach (model[i]) model[i] = 0;
        hit_total  = 0;
        beat       = 0;
        in_readout = 1'b0;
        clr_watch  = 1'b1;
        clr_len    = 0;
    endtask

    initial err_count = 0;

    always @(posedge clk or negedge res) begin
        int addr;
        if (!res) begin
            new_histogram();
            exp_num      = 0;
            cyc          = 0;
            last_hit_cyc = 0;
        end else begin
            cyc++;
            compare_value("hist_num", exp_num, hist_num);
            if (clr_watch) begin
                if (busy) begin
                    clr_len++;
                end else begin
                    if (clr_len != CELLS) begin
                        $display("clear sweep held busy for %0d cycles instead of %0d",
                                 clr_len, CELLS);
                        err_count++;
                    end
                    clr_watch = 1'b0;
                end
            end
            if (hit && !busy) begin
                if (hit_total >= HIST_HITS) begin
                    $display("hit accepted at %0t after the histogram was complete", $time);
                    err_count++;
                end else begin
                    addr        = ref_addr(hit_total, int'(hit_bin));
                    model[addr] = sat_add(model[addr]);
                    hit_total++;
                    last_hit_cyc = cyc;
                end
            end
            if (bin_valid) begin
                if (beat == 0) begin
                    if (hit_total != HIST_HITS) begin
                        $display("readout began after %0d of %0d hits", hit_total, HIST_HITS);
                        err_count++;
                    end
                    if (cyc - last_hit_cyc != FIRST_GAP) begin
                        $display("first bin came %0d cycles after the last hit, not %0d",
                                 cyc - last_hit_cyc, FIRST_GAP);
                        err_count++;
                    end
                    in_readout = 1'b1;
                end
                if (beat < CELLS) begin
                    compare_value("bin_pixel", beat / BIN_NUM, bin_pixel);
                    compare_value("bin_index", beat % BIN_NUM, bin_index);
                    compare_value("bin_count", model[beat], bin_count);
                end else begin
                    $display("readout produced more than %0d bins", CELLS);
                    err_count++;
                end
                compare_value("hist_done", beat == CELLS - 1, hist_done);
                beat++;
            end else if (in_readout) begin
                $display("bin_valid dropped at %0t in the middle of a readout", $time);
                err_count++;
                in_readout = 1'b0;
            end
            if (hist_done) begin
                if (!bin_valid) begin
                    $display("hist_done pulsed at %0t without a valid bin", $time);
                    err_count++;
                end
                new_histogram();
                exp_num = 1 - exp_num;  // toggle shows up one cycle later
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/sifh_hist_sva.sv
`timescale 1ns/10ps
`default_nettype none

module sifh_hist_sva
    import sifh_pkg::*;
(
    input logic        clk,
    input logic        res,
    input hist_state_t state,
    input logic        hit,
    input logic        busy,
    input logic        start,
    input logic        inc_en,
    input logic        clr_en
);

    int fail_count = 0;  // failed assertions so far

    // pending increment write lands one cycle after the strobe
    no_write_overlap: assert property (@(posedge clk) disable iff (!res)
        inc_en |=> !clr_en)
        else begin
            fail_count++;
            $error("clear strobe while an increment write was pending");
        end

    busy_falls_after_clear: assert property (@(posedge clk) disable iff (!res)
        $fell(busy) |-> $past(state) == CLEAR)
        else begin
            fail_count++;
            $error("busy dropped without a finished clear sweep");
        end

    // only the hit that completes a histogram ends accumulation
    busy_rises_on_hit: assert property (@(posedge clk) disable iff (!res)
        $rose(busy) |-> $past(hit) && state == DRAIN)
        else begin
            fail_count++;
            $error("busy rose without a completing hit");
        end

    start_single_cycle: assert property (@(posedge clk) disable iff (!res)
        start |=> !start)
        else begin
            fail_count++;
            $error("start held high for more than one cycle");
        end

endmodule

`default_nettype wire

// File: tb/tb_sifh_hist.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sifh_hist
    import sifh_pkg::*;
;

    localparam int BIN_NUM   = BIN_NUM_DEF;
    localparam int PIXEL_NUM = PIXEL_NUM_DEF;
    localparam int DATA_NUM  = DATA_NUM_DEF;
    localparam int ACQ_NUM   = 12;  // 96 hits per pixel go past the counter maximum
    localparam int COUNT_W   = COUNT_W_DEF;

    localparam int BIN_W      = $clog2(BIN_NUM);
    localparam int PIX_W      = $clog2(PIXEL_NUM);
    localparam int CELLS      = PIXEL_NUM * BIN_NUM;
    localparam int HIST_HITS  = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int N_HIST     = 3;
    localparam int SAT_BIN    = 9;
    // up to 4 cycles per hit plus clear and readout for each histogram
    localparam int MAX_CYCLES = N_HIST * (HIST_HITS * 4 + 2 * CELLS + 16) + 100;

    logic             clk = 1'b0;
    logic             res;
    logic             hit;
    logic [BIN_W-1:0] hit_bin;
    logic             busy;
    logic             bin_valid;
    logic [PIX_W-1:0] bin_pixel;
    logic [BIN_W-1:0] bin_index;
    logic [COUNT_W-1:0] bin_count;
    logic             hist_num;
    logic             hist_done;

    int          err_count;
    int          cycles = 0;
    int          hist_seen;
    logic [31:0] lfsr;

    always #10 clk = ~clk;

    sifh_hist_top #(
        .BIN_NUM   (BIN_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM),
        .COUNT_W   (COUNT_W)
    ) u_sifh_hist_top (
        .clk       (clk),
        .res       (res),
        .hit       (hit),
        .hit_bin   (hit_bin),
        .busy      (busy),
        .bin_valid (bin_valid),
        .bin_pixel (bin_pixel),
        .bin_index (bin_index),
        .bin_count (bin_count),
        .hist_num  (hist_num),
        .hist_done (hist_done)
    );

    hist_checker #(
        .BIN_NUM   (BIN_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM),
        .COUNT_W   (COUNT_W)
    ) u_hist_checker (
        .clk       (clk),
        .res       (res),
        .hit       (hit),
        .hit_bin   (hit_bin),
        .busy      (busy),
        .bin_valid (bin_valid),
        .bin_pixel (bin_pixel),
        .bin_index (bin_index),
        .bin_count (bin_count),
        .hist_num  (hist_num),
        .hist_done (hist_done),
        .err_count (err_count)
    );

    bind hist_sequencer sifh_hist_sva u_seq_sva (
        .clk    (clk),
        .res    (res),
        .state  (state),
        .hit    (hit),
        .busy   (busy),
        .start  (start),
        .inc_en (bank.inc_en),
        .clr_en (bank.clr_en)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic close_run(input bit timed_out);
        int sva_fails;
        sva_fails = u_sifh_hist_top.u_hist_sequencer.u_seq_sva.fail_count;
        $display("checker errors: %0d, assertion failures: %0d", err_count, sva_fails);
        if (timed_out || err_count != 0 || sva_fails != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run timed out after %0d cycles, %0d of %0d histograms read out",
                     cycles, hist_seen, N_HIST);
            close_run(1'b1);
        end
    end

    // hits keep coming while busy and must be dropped
    initial begin
        int bits;
        int run_left;
        int run_bin;
        $timeformat(-9, 1, " ns", 10);
        res       = 1'b0;
        hit       = 1'b0;
        hit_bin   = '0;
        lfsr      = 32'h5caa0a2a;
        run_left  = 0;
        run_bin   = 0;
        hist_seen = 0;
        repeat (2) @(posedge clk);
        res <= 1'b1;
        while (hist_seen < N_HIST) begin
            @(posedge clk);
            if (hist_done) begin
                hist_seen++;
            end
            case (hist_seen)
                0: begin
                    // random hits into the lower half of the bins
                    take_bits(1, bits);
                    hit <= bits[0];
                    if (bits[0]) begin
                        take_bits(3, bits);
                        hit_bin <= BIN_W'(bits);
                    end
                end
                1: begin
                    hit     <= 1'b1;  // same bin every cycle for forwarding and saturation
                    hit_bin <= BIN_W'(SAT_BIN);
                end
                default: begin
                    if (run_left == 0) begin
                        take_bits(3, bits);
                        run_left = bits + 1;
                        take_bits(BIN_W, bits);
                        run_bin = bits;
                    end
                    run_left--;
                    hit     <= 1'b1;
                    hit_bin <= BIN_W'(run_bin);
                end
            endcase
        end
        hit <= 1'b0;
        repeat (2) @(posedge clk);  // let the hist_num toggle be checked
        @(negedge clk);
        close_run(1'b0);
    end

endmodule

`default_nettype wire
